//--- addrMapPkg.sv
package addrMapPkg;

    // bus geometry
    localparam int addrWidth = 13;
    localparam int dataWidth = 32;

    // register field widths
    localparam int modeWidth = 5;
    localparam int lenWidth  = 16;

    localparam logic [addrWidth-1:0] vitControl       = 13'h0000;
    localparam logic [addrWidth-1:0] vitInverseMean   = 13'h0004;
    localparam logic [addrWidth-1:0] vitBerTestLength = 13'h0008;
    localparam logic [addrWidth-1:0] vitStatus        = 13'h000C; // read only

    // inverse mean word layout
    localparam int invMantLsb = 0;
    localparam int invExpLsb  = 16;

    // status word layout
    localparam int statCh1InSync   = 31;
    localparam int statCh0InSync   = 30;
    localparam int statCh1StateLsb = 4;
    localparam int statCh0StateLsb = 0;

    localparam int modeCh0En  = 0;
    localparam int modeCh1En  = 1;
    localparam int modeInvert = 2;
    localparam int modeThrLo  = 3;  // two bits wide up to bit 4

endpackage

//--- berSyncTracker.sv
`timescale 1ns/1ps

module berSyncTracker (
    input  logic                                busClk,
    input  logic                                arstN,
    input  logic                                symbolDone,
    input  logic                                symbolBit,
    input  logic [addrMapPkg::lenWidth-1:0]     frameLength,
    input  logic [symbolPkg::thrSelWidth-1:0]   thresholdSel,
    output logic [symbolPkg::stateWidth-1:0]    syncState,
    output logic                                inSync
);

    logic [symbolPkg::pnWidth-1:0]      pnReg;
    logic                               refBit;
    logic                               bitErr;
    logic                               active;
    logic                               frameEnd;
    logic                               frameGood;
    logic [addrMapPkg::lenWidth-1:0]    symCount;
    logic [addrMapPkg::lenWidth-1:0]    errCount;
    logic [addrMapPkg::lenWidth-1:0]    errTotal;
    logic [addrMapPkg::lenWidth-1:0]    errLimit;
    logic [symbolPkg::stateWidth-1:0]   stateNext;

    assign refBit = pnReg[symbolPkg::pnTapA-1] ^ pnReg[symbolPkg::pnTapB-1];
    assign bitErr = symbolBit ^ refBit;

    // zero length freezes the tracker
    assign active   = symbolDone && (frameLength != '0);
    assign frameEnd = (symCount >= frameLength - 1'b1);

    // count includes the symbol arriving now
    assign errTotal  = errCount + addrMapPkg::lenWidth'(bitErr);
    assign errLimit  = addrMapPkg::lenWidth'(symbolPkg::errThresholds[thresholdSel]);
    assign frameGood = (errTotal <= errLimit);

    always_comb begin
        if (frameGood) begin
            if (syncState == symbolPkg::stateWidth'(symbolPkg::stateMax))
                stateNext = syncState;
            else
                stateNext = syncState + 1'b1;
        end else begin
            if (syncState == '0)
                stateNext = syncState;
            else
                stateNext = syncState - 1'b1;
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            pnReg     <= symbolPkg::pnSeed;
            symCount  <= '0;
            errCount  <= '0;
            syncState <= '0;
            inSync    <= 1'b0;
        end else if (active) begin
            pnReg <= {pnReg[symbolPkg::pnWidth-2:0], refBit};
            if (frameEnd) begin
                symCount  <= '0;
                errCount  <= '0;
                syncState <= stateNext;
                // only the two end states move the flag
                if (stateNext == symbolPkg::stateWidth'(symbolPkg::stateMax))
                    inSync <= 1'b1;
                else if (stateNext == '0)
                    inSync <= 1'b0;
            end else begin
                symCount <= symCount + 1'b1;
                errCount <= errTotal;
            end
        end
    end

endmodule

//--- build.f
addrMapPkg.sv
symbolPkg.sv
viterbiRegs.sv
softScaler.sv
berSyncTracker.sv
viterbiFrontEnd.sv
+incdir+.
tbViterbiFrontEnd.sv

//--- softScaler.sv
`timescale 1ns/1ps

module softScaler (
    input  logic                                    busClk,
    input  logic                                    arstN,
    input  logic                                    enable,
    input  logic                                    invert,
    input  logic [symbolPkg::mantWidth-1:0]         mantissa,
    input  logic [symbolPkg::expWidth-1:0]          exponent,
    input  logic                                    inReq,
    output logic                                    inAck,
    input  logic signed [symbolPkg::sampleWidth-1:0] sample,
    output logic                                    outReq,
    input  logic                                    outAck,
    output logic signed [symbolPkg::metricWidth-1:0] metric,
    output logic                                    symbolDone,
    output logic                                    symbolBit
);

    typedef enum logic [1:0] {outEmpty, outLoaded, outBusy, outDrain} outStateT;

    outStateT outState;
    logic     inFull;
    logic     capture;
    logic     move;
    logic     outFree;
    logic [symbolPkg::shiftWidth-1:0]                           shiftAmt;
    logic signed [symbolPkg::sampleWidth:0]                     sampleAdj; // room for -(-128)
    logic signed [symbolPkg::sampleWidth+symbolPkg::mantWidth+1:0] product;
    logic signed [symbolPkg::sampleWidth+symbolPkg::mantWidth+1:0] shifted;
    logic signed [symbolPkg::metricWidth-1:0]                   scaled;
    logic signed [symbolPkg::metricWidth-1:0]                   inMetric;

    assign shiftAmt = symbolPkg::shiftWidth'(symbolPkg::scaleShiftBase - int'(exponent));

    always_comb begin
        sampleAdj = (symbolPkg::sampleWidth+1)'(sample);
        if (invert)
            sampleAdj = -sampleAdj;
        product = sampleAdj * $signed({1'b0, mantissa});
        shifted = product >>> shiftAmt;
        if (shifted > symbolPkg::metricMax)
            scaled = symbolPkg::metricWidth'(symbolPkg::metricMax);
        else if (shifted < -symbolPkg::metricMax)
            scaled = symbolPkg::metricWidth'(-symbolPkg::metricMax);
        else
            scaled = shifted[symbolPkg::metricWidth-1:0];
    end

    assign capture = inReq && !inAck && enable && !inFull;
    assign outFree = (outState == outEmpty) || (outState == outDrain && !outAck);
    assign move    = inFull && outFree;
    assign outReq  = (outState == outBusy);

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            inAck      <= 1'b0;
            inFull     <= 1'b0;
            outState   <= outEmpty;
            symbolDone <= 1'b0;
            symbolBit  <= 1'b0;
        end else begin
            symbolDone <= 1'b0;
            if (capture) begin
                inAck  <= 1'b1;
                inFull <= 1'b1;
            end else begin
                if (inAck && !inReq)
                    inAck <= 1'b0;  // source has released req
                if (move)
                    inFull <= 1'b0;
            end
            case (outState)
                outEmpty:  if (move) outState <= outLoaded;
                outLoaded: outState <= outBusy;
                outBusy: begin
                    if (outAck) begin
                        outState   <= outDrain;
                        symbolDone <= 1'b1;
                        symbolBit  <= metric[symbolPkg::metricWidth-1];
                    end
                end
                outDrain:  if (!outAck) outState <= move ? outLoaded : outEmpty;
                default:   outState <= outEmpty;
            endcase
        end
    end

    always_ff @(posedge busClk) begin
        if (capture)
            inMetric <= scaled;
        if (move)
            metric <= inMetric;
    end

endmodule

//--- symbolPkg.sv
package symbolPkg;

    // soft sample in, soft metric out
    localparam int sampleWidth = 8;
    localparam int metricWidth = 4;
    localparam int metricMax   = 7;     // symmetric clamp so -8 never appears

    // inverse mean scaling
    localparam int mantWidth      = 16;
    localparam int expWidth       = 3;
    localparam int scaleShiftBase = 12;
    localparam int shiftWidth     = 4;  // holds 5..12

    // PN9 reference x^9 + x^5 + 1
    localparam int pnWidth = 9;
    localparam logic [pnWidth-1:0] pnSeed = 9'h1FF;
    localparam int pnTapA  = 9;
    localparam int pnTapB  = 5;

    // sync tracking
    localparam int stateWidth  = 4;
    localparam int stateMax    = 15;
    localparam int thrSelWidth = 2;

    // allowed errors per frame picked by mode bits 4..3
    localparam logic [3:0][3:0] errThresholds = {
        4'd7,
        4'd3,
        4'd1,
        4'd0
    };

endpackage

//--- tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
endtask

task automatic checkMetric(input logic signed [symbolPkg::metricWidth-1:0] got,
                           input logic signed [symbolPkg::metricWidth-1:0] expected,
                           input string what);
    if (got !== expected)
        failRun($sformatf("MISMATCH at %0t: %s metric %0d, expected %0d",
                          $time, what, got, expected));
endtask

task automatic checkWord(input logic [addrMapPkg::dataWidth-1:0] got,
                         input logic [addrMapPkg::dataWidth-1:0] expected,
                         input string what);
    if (got !== expected)
        failRun($sformatf("MISMATCH at %0t: %s read %h, expected %h",
                          $time, what, got, expected));
endtask

task automatic checkSync(input logic [symbolPkg::stateWidth-1:0] gotState,
                         input logic [symbolPkg::stateWidth-1:0] expState,
                         input logic gotFlag, input logic expFlag, input string what);
    if (gotState !== expState || gotFlag !== expFlag)
        failRun($sformatf("MISMATCH at %0t: %s state %0d/%0b, expected %0d/%0b",
                          $time, what, gotState, gotFlag, expState, expFlag));
endtask

// galois lfsr stepped once per bit
function automatic logic lfsrBit();
    logic b;
    b = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (b)
        lfsrState = lfsrState ^ 32'hA300_0000;
    return b;
endfunction

`endif

//--- tbViterbiFrontEnd.sv
`timescale 1ns/1ps

module tbViterbiFrontEnd;

    localparam int totalSymbols = 6 * 2 * 24 + 40 * 2 * 16;
    localparam int cycleLimit   = 40 * totalSymbols + 2000;

    logic busClk, arstN, cs, wr0, wr1, wr2, wr3;
    logic [addrMapPkg::addrWidth-1:0] addr;
    logic [addrMapPkg::dataWidth-1:0] dataIn, dataOut;
    logic inReq [2];
    logic inAck [2];
    logic outReq [2];
    logic outAck [2];
    logic signed [7:0] sample [2];
    logic signed [3:0] metric [2];
    logic inSync [2];
    logic [3:0] syncState [2];
    logic [31:0] lfsrState = 32'd87144;
    logic signed [7:0] srcQ0 [$], srcQ1 [$];
    logic signed [3:0] expQ0 [$], expQ1 [$];
    logic [15:0] curMant;
    logic [2:0] curExp;
    logic curInv;
    logic [8:0] pnModel [2];
    int stateModel [2];
    logic syncModel [2];
    int cycles = 0;

    `include "tbChecks.svh"

    viterbiFrontEnd dut (
        .busClk, .arstN, .cs, .wr0, .wr1, .wr2, .wr3, .addr, .dataIn, .dataOut,
        .ch0InReq(inReq[0]), .ch0InAck(inAck[0]), .ch0Sample(sample[0]),
        .ch0OutReq(outReq[0]), .ch0OutAck(outAck[0]), .ch0Metric(metric[0]),
        .ch1InReq(inReq[1]), .ch1InAck(inAck[1]), .ch1Sample(sample[1]),
        .ch1OutReq(outReq[1]), .ch1OutAck(outAck[1]), .ch1Metric(metric[1]),
        .ch0InSync(inSync[0]), .ch1InSync(inSync[1]),
        .ch0SyncState(syncState[0]), .ch1SyncState(syncState[1])
    );

    initial begin
        busClk = 1'b0;
        forever #10 busClk = ~busClk;
    end

    always @(posedge busClk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit)
            failRun("timeout reached before all tests finished");
    end

    // reference scaling with floor shift and clamp to +-7
    function automatic logic signed [3:0] expMetric(input logic signed [7:0] s,
            input logic [15:0] mant, input logic [2:0] ex, input logic inv);
        int v;
        v = inv ? -int'(s) : int'(s);
        v = (v * int'(mant)) >>> (12 - int'(ex));
        if (v > 7)
            v = 7;
        else if (v < -7)
            v = -7;
        return 4'(v);
    endfunction

    function automatic logic [7:0] randBits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[6:0], lfsrBit()};
        return r;
    endfunction

    task automatic busWrite(input logic [12:0] a, input logic [31:0] d, input logic [3:0] be);
        @(posedge busClk);
        cs <= 1'b1;
        addr <= a;
        dataIn <= d;
        {wr3, wr2, wr1, wr0} <= be;
        @(posedge busClk);
        cs <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'b0;
    endtask

    task automatic busRead(input logic [12:0] a, output logic [31:0] d);
        @(posedge busClk);
        cs <= 1'b1;
        addr <= a;
        @(negedge busClk);
        d = dataOut;
        @(posedge busClk);
        cs <= 1'b0;
    endtask

    task automatic enqueue(input int ch, input logic signed [7:0] s);
        if (ch == 0) begin
            srcQ0.push_back(s);
            expQ0.push_back(expMetric(s, curMant, curExp, curInv));
        end else begin
            srcQ1.push_back(s);
            expQ1.push_back(expMetric(s, curMant, curExp, curInv));
        end
    endtask

    task automatic source(input int ch);
        forever begin
            @(posedge busClk);
            if ((ch == 0 && srcQ0.size() != 0) || (ch == 1 && srcQ1.size() != 0)) begin
                sample[ch] <= (ch == 0) ? srcQ0.pop_front() : srcQ1.pop_front();
                inReq[ch] <= 1'b1;
                do @(posedge busClk); while (!inAck[ch]);
                inReq[ch] <= 1'b0;
                do @(posedge busClk); while (inAck[ch]);
            end
        end
    endtask

    // sink with random ack delay that compares each metric in order
    task automatic sink(input int ch);
        int delay;
        logic signed [3:0] expected;
        forever begin
            do @(posedge busClk); while (!outReq[ch]);
            delay = randBits(3);
            repeat (delay) @(posedge busClk);
            if ((ch == 0 && expQ0.size() == 0) || (ch == 1 && expQ1.size() == 0))
                failRun($sformatf("channel %0d delivered a metric nobody sent", ch));
            expected = (ch == 0) ? expQ0.pop_front() : expQ1.pop_front();
            checkMetric(metric[ch], expected, $sformatf("channel %0d", ch));
            outAck[ch] <= 1'b1;
            do @(posedge busClk); while (outReq[ch]);
            outAck[ch] <= 1'b0;
        end
    endtask

    task automatic waitIdle();
        do @(posedge busClk);
        while (srcQ0.size() + srcQ1.size() + expQ0.size() + expQ1.size() != 0 ||
               outReq[0] || outReq[1] || inAck[0] || inAck[1]);
        repeat (3) @(posedge busClk);  // symbolDone then state update
    endtask

    task automatic setScale(input logic [15:0] m, input logic [2:0] e, input logic inv);
        busWrite(addrMapPkg::vitInverseMean, {13'b0, e, m}, 4'b0111);
        busWrite(addrMapPkg::vitControl, 32'(3 | (inv << 2)), 4'b0001);
        curMant = m;
        curExp = e;
        curInv = inv;
    endtask

    // one 16-symbol frame per channel with nErr sign errors and a status check after it
    task automatic runFrame(input int nErr, input int sel);
        int thr [4] = '{0, 1, 3, 7};
        logic refBit;
        logic [31:0] status;
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < 16; i++) begin
                refBit = pnModel[ch][8] ^ pnModel[ch][4];
                pnModel[ch] = {pnModel[ch][7:0], refBit};
                enqueue(ch, (refBit ^ (i < nErr)) ? -8'sd5 : 8'sd5);
            end
            if (nErr <= thr[sel])
                stateModel[ch] = (stateModel[ch] < 15) ? stateModel[ch] + 1 : 15;
            else
                stateModel[ch] = (stateModel[ch] > 0) ? stateModel[ch] - 1 : 0;
            if (stateModel[ch] == 15)
                syncModel[ch] = 1'b1;
            else if (stateModel[ch] == 0)
                syncModel[ch] = 1'b0;
        end
        waitIdle();
        checkSync(syncState[0], 4'(stateModel[0]), inSync[0], syncModel[0], "ch0 ports");
        checkSync(syncState[1], 4'(stateModel[1]), inSync[1], syncModel[1], "ch1 ports");
        busRead(addrMapPkg::vitStatus, status);
        checkSync(status[3:0], 4'(stateModel[0]), status[30], syncModel[0], "ch0 status");
        checkSync(status[7:4], 4'(stateModel[1]), status[31], syncModel[1], "ch1 status");
    endtask

    initial source(0);
    initial source(1);
    initial sink(0);
    initial sink(1);

    initial begin
        logic [31:0] rd;
        logic [15:0] mants [3] = '{16'd4096, 16'd1000, 16'd65535};
        logic [2:0] exps [3] = '{3'd0, 3'd3, 3'd0};
        arstN = 1'b0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0;
        addr = '0;
        dataIn = '0;
        for (int ch = 0; ch < 2; ch++) begin
            inReq[ch] = 1'b0;
            outAck[ch] = 1'b0;
            sample[ch] = '0;
            pnModel[ch] = 9'h1FF;
            stateModel[ch] = 0;
            syncModel[ch] = 1'b0;
        end
        repeat (8) @(posedge busClk);
        arstN <= 1'b1;

        // unwritten byte lanes stay zero
        busWrite(addrMapPkg::vitInverseMean, 32'hFFFF_FFFF, 4'b0001);
        busRead(addrMapPkg::vitInverseMean, rd);
        checkWord(rd, 32'h0000_00FF, "inverse mean low lane");
        busWrite(addrMapPkg::vitInverseMean, 32'hFFFF_FFFF, 4'b1110);
        busRead(addrMapPkg::vitInverseMean, rd);
        checkWord(rd, 32'h0007_FFFF, "inverse mean all lanes");
        busWrite(addrMapPkg::vitBerTestLength, 32'hA5C3_1234, 4'b0010);
        busRead(addrMapPkg::vitBerTestLength, rd);
        checkWord(rd, 32'h0000_1200, "length high lane");
        busWrite(addrMapPkg::vitBerTestLength, 32'hA5C3_1234, 4'b0001);
        busRead(addrMapPkg::vitBerTestLength, rd);
        checkWord(rd, 32'h0000_1234, "length both lanes");
        busWrite(addrMapPkg::vitControl, 32'hFFFF_FFFF, 4'b1110);
        busRead(addrMapPkg::vitControl, rd);
        checkWord(rd, 32'h0, "control upper lanes");
        busWrite(addrMapPkg::vitControl, 32'hFFFF_FFFF, 4'b0001);
        busRead(addrMapPkg::vitControl, rd);
        checkWord(rd, 32'h0000_001F, "control mode");
        busRead(addrMapPkg::vitStatus, rd);
        checkWord(rd, 32'h0, "status after reset");
        busWrite(addrMapPkg::vitBerTestLength, 32'h0, 4'b0011);  // tracker frozen

        // disabled channel must not answer
        busWrite(addrMapPkg::vitControl, 32'h1, 4'b0001);
        inReq[1] <= 1'b1;
        repeat (20) begin
            @(posedge busClk);
            checkWord(32'(inAck[1]), 32'h0, "inAck of disabled channel");
        end
        inReq[1] <= 1'b0;

        for (int c = 0; c < 6; c++) begin
            setScale(mants[c % 3], exps[c % 3], c >= 3);
            for (int i = 0; i < 24; i++) begin
                enqueue(0, randBits(8));
                enqueue(1, randBits(8));
            end
            waitIdle();
        end

        setScale(16'd4096, 3'd0, 1'b0);
        busWrite(addrMapPkg::vitBerTestLength, 32'd16, 4'b0011);
        for (int f = 0; f < 16; f++)
            runFrame(0, 0);
        for (int f = 0; f < 16; f++)
            runFrame(2, 0);
        for (int sel = 0; sel < 4; sel++) begin
            busWrite(addrMapPkg::vitControl, 32'(3 | (sel << 3)), 4'b0001);
            runFrame(sel == 0 ? 0 : (sel == 1 ? 1 : (sel == 2 ? 3 : 7)), sel);
            runFrame(sel == 0 ? 1 : (sel == 1 ? 2 : (sel == 2 ? 4 : 8)), sel);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- viterbiFrontEnd.sv
`timescale 1ns/1ps

module viterbiFrontEnd (
    input  logic                                        busClk,
    input  logic                                        arstN,
    input  logic                                        cs,
    input  logic                                        wr0,
    input  logic                                        wr1,
    input  logic                                        wr2,
    input  logic                                        wr3,
    input  logic [addrMapPkg::addrWidth-1:0]            addr,
    input  logic [addrMapPkg::dataWidth-1:0]            dataIn,
    output logic [addrMapPkg::dataWidth-1:0]            dataOut,
    input  logic                                        ch0InReq,
    output logic                                        ch0InAck,
    input  logic signed [symbolPkg::sampleWidth-1:0]    ch0Sample,
    output logic                                        ch0OutReq,
    input  logic                                        ch0OutAck,
    output logic signed [symbolPkg::metricWidth-1:0]    ch0Metric,
    input  logic                                        ch1InReq,
    output logic                                        ch1InAck,
    input  logic signed [symbolPkg::sampleWidth-1:0]    ch1Sample,
    output logic                                        ch1OutReq,
    input  logic                                        ch1OutAck,
    output logic signed [symbolPkg::metricWidth-1:0]    ch1Metric,
    output logic                                        ch0InSync,
    output logic                                        ch1InSync,
    output logic [symbolPkg::stateWidth-1:0]            ch0SyncState,
    output logic [symbolPkg::stateWidth-1:0]            ch1SyncState
);

    logic [addrMapPkg::modeWidth-1:0]   viterbiMode;
    logic [symbolPkg::mantWidth-1:0]    inverseMeanMantissa;
    logic [symbolPkg::expWidth-1:0]     inverseMeanExponent;
    logic [addrMapPkg::lenWidth-1:0]    berTestLength;
    logic [symbolPkg::thrSelWidth-1:0]  thresholdSel;
    logic                               ch0SymbolDone;
    logic                               ch0SymbolBit;
    logic                               ch1SymbolDone;
    logic                               ch1SymbolBit;

    assign thresholdSel = viterbiMode[addrMapPkg::modeThrLo +: symbolPkg::thrSelWidth];

    viterbiRegs regs (
        .busClk, .arstN, .cs, .wr0, .wr1, .wr2, .wr3, .addr, .dataIn, .dataOut,
        .ch0InSync, .ch1InSync, .ch0SyncState, .ch1SyncState,
        .viterbiMode, .inverseMeanMantissa, .inverseMeanExponent, .berTestLength
    );

    softScaler scaler0 (
        .busClk, .arstN,
        .enable(viterbiMode[addrMapPkg::modeCh0En]),
        .invert(viterbiMode[addrMapPkg::modeInvert]),
        .mantissa(inverseMeanMantissa), .exponent(inverseMeanExponent),
        .inReq(ch0InReq), .inAck(ch0InAck), .sample(ch0Sample),
        .outReq(ch0OutReq), .outAck(ch0OutAck), .metric(ch0Metric),
        .symbolDone(ch0SymbolDone), .symbolBit(ch0SymbolBit)
    );

    softScaler scaler1 (
        .busClk, .arstN,
        .enable(viterbiMode[addrMapPkg::modeCh1En]),
        .invert(viterbiMode[addrMapPkg::modeInvert]),
        .mantissa(inverseMeanMantissa), .exponent(inverseMeanExponent),
        .inReq(ch1InReq), .inAck(ch1InAck), .sample(ch1Sample),
        .outReq(ch1OutReq), .outAck(ch1OutAck), .metric(ch1Metric),
        .symbolDone(ch1SymbolDone), .symbolBit(ch1SymbolBit)
    );

    berSyncTracker tracker0 (
        .busClk, .arstN, .symbolDone(ch0SymbolDone), .symbolBit(ch0SymbolBit),
        .frameLength(berTestLength), .thresholdSel,
        .syncState(ch0SyncState), .inSync(ch0InSync)
    );

    berSyncTracker tracker1 (
        .busClk, .arstN, .symbolDone(ch1SymbolDone), .symbolBit(ch1SymbolBit),
        .frameLength(berTestLength), .thresholdSel,
        .syncState(ch1SyncState), .inSync(ch1InSync)
    );

endmodule

//--- viterbiRegs.sv
`timescale 1ns/1ps

module viterbiRegs (
    input  logic                                busClk,
    input  logic                                arstN,
    input  logic                                cs,
    input  logic                                wr0,
    input  logic                                wr1,
    input  logic                                wr2,
    input  logic                                wr3,
    input  logic [addrMapPkg::addrWidth-1:0]    addr,
    input  logic [addrMapPkg::dataWidth-1:0]    dataIn,
    output logic [addrMapPkg::dataWidth-1:0]    dataOut,
    input  logic                                ch0InSync,
    input  logic                                ch1InSync,
    input  logic [symbolPkg::stateWidth-1:0]    ch0SyncState,
    input  logic [symbolPkg::stateWidth-1:0]    ch1SyncState,
    output logic [addrMapPkg::modeWidth-1:0]    viterbiMode,
    output logic [symbolPkg::mantWidth-1:0]     inverseMeanMantissa,
    output logic [symbolPkg::expWidth-1:0]      inverseMeanExponent,
    output logic [addrMapPkg::lenWidth-1:0]     berTestLength
);

    // lane 3 has no writable field
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            viterbiMode         <= '0;
            inverseMeanMantissa <= '0;
            inverseMeanExponent <= '0;
            berTestLength       <= '0;
        end else begin
            if (cs && wr0) begin
                case (addr)
                    addrMapPkg::vitControl:
                        viterbiMode <= dataIn[addrMapPkg::modeWidth-1:0];
                    addrMapPkg::vitInverseMean:
                        inverseMeanMantissa[7:0] <= dataIn[7:0];
                    addrMapPkg::vitBerTestLength:
                        berTestLength[7:0] <= dataIn[7:0];
                    default: ;
                endcase
            end
            if (cs && wr1) begin
                case (addr)
                    addrMapPkg::vitInverseMean:
                        inverseMeanMantissa[15:8] <= dataIn[15:8];
                    addrMapPkg::vitBerTestLength:
                        berTestLength[15:8] <= dataIn[15:8];
                    default: ;
                endcase
            end
            if (cs && wr2 && (addr == addrMapPkg::vitInverseMean)) begin
                inverseMeanExponent <=
                    dataIn[addrMapPkg::invExpLsb +: symbolPkg::expWidth];
            end
        end
    end

    // readback is zero outside the selected register
    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                addrMapPkg::vitControl: begin
                    dataOut[addrMapPkg::modeWidth-1:0] = viterbiMode;
                end
                addrMapPkg::vitInverseMean: begin
                    dataOut[addrMapPkg::invMantLsb +: symbolPkg::mantWidth] =
                        inverseMeanMantissa;
                    dataOut[addrMapPkg::invExpLsb +: symbolPkg::expWidth] =
                        inverseMeanExponent;
                end
                addrMapPkg::vitBerTestLength: begin
                    dataOut[addrMapPkg::lenWidth-1:0] = berTestLength;
                end
                addrMapPkg::vitStatus: begin
                    dataOut[addrMapPkg::statCh1InSync] = ch1InSync;
                    dataOut[addrMapPkg::statCh0InSync] = ch0InSync;
                    dataOut[addrMapPkg::statCh1StateLsb +: symbolPkg::stateWidth] =
                        ch1SyncState;
                    dataOut[addrMapPkg::statCh0StateLsb +: symbolPkg::stateWidth] =
                        ch0SyncState;
                end
                default: ;
            endcase
        end
    end

endmodule
